//--- verilog/periph_consts.svh
/*
 * Constants of the APB peripheral subsystem: bus widths, the slot map,
 * register word offsets, reset values and interrupt bit positions.
 * Include it wherever the register map or the widths are needed.
 */
`ifndef PERIPH_CONSTS_SVH
`define PERIPH_CONSTS_SVH

// Bus and address split
`define PERIPH_DATA_W        32
`define PERIPH_SLOT_LSB      12
`define PERIPH_SLOT_W        4
`define PERIPH_OFF_W         10
`define PERIPH_NUM_SLOTS     4

// Slot numbers
`define PERIPH_SLOT_GPIO     0
`define PERIPH_SLOT_TIMER    1
`define PERIPH_SLOT_EVENT    2
`define PERIPH_SLOT_SOC      3

// GPIO word offsets
`define GPIO_DIR             10'd0
`define GPIO_IN              10'd1
`define GPIO_OUT             10'd2
`define GPIO_INTEN           10'd3
`define GPIO_STATUS          10'd4

// Timer word offsets
`define TIM_COUNT            10'd0
`define TIM_CTRL             10'd1
`define TIM_CMP              10'd2

// Event unit word offsets
`define EVT_MASK             10'd0
`define EVT_PENDING          10'd1

// SoC control word offsets
`define SOC_BOOT             10'd0
`define SOC_CLKGATE          10'd1
`define SOC_PADMUX           10'd2

// Reset values, all peripherals enabled
`define PERIPH_BOOT_RESET    32'h0001_0000
`define PERIPH_CLKGATE_RESET 3'd7

// Enable bits in CLKGATE
`define CLKGATE_GPIO_BIT     0
`define CLKGATE_TIMER_BIT    1
`define CLKGATE_EVENT_BIT    2

// Interrupt lines in the event unit
`define EVT_GPIO_BIT         25
`define EVT_TIMER_BIT        28

`define GPIO_SYNC_STAGES     2

`endif

//--- verilog/periph_pkg.sv
/*
 * Shared types of the peripheral subsystem.
 * Modules use the scoped names in their port lists and import the
 * package inside the body for local declarations.
 */
`include "periph_consts.svh"

package periph_pkg;

  // One APB data word
  typedef logic [`PERIPH_DATA_W-1:0] word_t;

  // Register word offset inside a slot, paddr bits 11 to 2
  typedef logic [`PERIPH_OFF_W-1:0] reg_off_t;

  // One bit per mapped slot, used for strobes and enables
  typedef logic [`PERIPH_NUM_SLOTS-1:0] slot_vec_t;

endpackage

//--- verilog/periph_apb_decode.sv
/*
 * APB slave port of the subsystem. Splits paddr into slot and offset,
 * raises one write or read strobe per access phase, muxes the slot
 * read data back and flags unmapped or disabled slots with pslverr.
 */
`timescale 1ns/1ps
`include "periph_consts.svh"

module periph_apb_decode (
  input  logic                  clk_int,
  input  logic                  rst_n_i,
  input  logic                  psel_i,
  input  logic                  penable_i,
  input  logic                  pwrite_i,
  input  periph_pkg::word_t     paddr_i,
  input  periph_pkg::slot_vec_t clk_gate_i,
  input  periph_pkg::word_t     gpio_rdata_i,
  input  periph_pkg::word_t     timer_rdata_i,
  input  periph_pkg::word_t     evt_rdata_i,
  input  periph_pkg::word_t     soc_rdata_i,
  output periph_pkg::slot_vec_t slot_wr_o,
  output periph_pkg::slot_vec_t slot_rd_o,
  output periph_pkg::reg_off_t  reg_off_o,
  output periph_pkg::word_t     prdata_o,
  output logic                  pready_o,
  output logic                  pslverr_o
);
  import periph_pkg::*;

  logic [`PERIPH_SLOT_W-1:0] slot;
  slot_vec_t                 gate_eff;
  slot_vec_t                 slot_sel;
  logic                      access;

  //////////////////////////////////////////////////
  // Address split
  //////////////////////////////////////////////////

  assign slot      = paddr_i[`PERIPH_SLOT_LSB +: `PERIPH_SLOT_W];
  assign reg_off_o = paddr_i[`PERIPH_OFF_W+1:2];
  assign access    = psel_i && penable_i;

  // SoC control can never lock itself out
  always_comb begin
    gate_eff                   = clk_gate_i;
    gate_eff[`PERIPH_SLOT_SOC] = 1'b1;
  end

  // One-hot slot select, empty for slots 4..15 or a disabled peripheral
  always_comb begin
    for (int i = 0; i < `PERIPH_NUM_SLOTS; i++) begin
      slot_sel[i] = (slot == i) && gate_eff[i];
    end
  end

  //////////////////////////////////////////////////
  // Strobes and response
  //////////////////////////////////////////////////

  assign slot_wr_o = (access && pwrite_i)  ? slot_sel : '0;
  assign slot_rd_o = (access && !pwrite_i) ? slot_sel : '0;

  // No wait states
  assign pready_o  = access;
  assign pslverr_o = access && (slot_sel == '0);

  // Rejected accesses read zero
  always_comb begin
    unique case (slot_sel)
      slot_vec_t'(1 << `PERIPH_SLOT_GPIO):  prdata_o = gpio_rdata_i;
      slot_vec_t'(1 << `PERIPH_SLOT_TIMER): prdata_o = timer_rdata_i;
      slot_vec_t'(1 << `PERIPH_SLOT_EVENT): prdata_o = evt_rdata_i;
      slot_vec_t'(1 << `PERIPH_SLOT_SOC):   prdata_o = soc_rdata_i;
      default:                              prdata_o = '0;
    endcase
  end

  // A single peripheral sees a strobe per access
  a_one_strobe: assert property (@(posedge clk_int) disable iff (!rst_n_i)
    $onehot0(slot_wr_o | slot_rd_o));

  // An error response only ends an access phase and reaches no peripheral
  a_err_access: assert property (@(posedge clk_int) disable iff (!rst_n_i)
    pslverr_o |-> (psel_i && penable_i && (slot_wr_o | slot_rd_o) == '0));

endmodule

//--- verilog/periph_soc_ctrl.sv
/*
 * SoC control slot. Holds the boot address, the peripheral enables
 * and the pad mux, and drives them straight to the subsystem.
 * The enables freeze a peripheral and make the decoder reject it.
 */
`timescale 1ns/1ps
`include "periph_consts.svh"

module periph_soc_ctrl (
  input  logic                  clk_int,
  input  logic                  rst_n_i,
  input  logic                  wr_i,
  input  logic                  rd_i,
  input  periph_pkg::reg_off_t  off_i,
  input  periph_pkg::word_t     wdata_i,
  output periph_pkg::word_t     rdata_o,
  output periph_pkg::word_t     boot_addr_o,
  output periph_pkg::slot_vec_t clk_gate_o,
  output periph_pkg::word_t     pad_mux_o
);
  import periph_pkg::*;

  word_t boot_q;
  word_t padmux_q;
  // Enables of the three gated slots, SoC slot has none
  logic [`PERIPH_NUM_SLOTS-2:0] gate_q;

  //////////////////////////////////////////////////
  // Register writes
  //////////////////////////////////////////////////

  always_ff @(posedge clk_int or negedge rst_n_i) begin
    if (!rst_n_i) begin
      boot_q   <= `PERIPH_BOOT_RESET;
      gate_q   <= `PERIPH_CLKGATE_RESET;
      padmux_q <= '0;
    end else if (wr_i) begin
      case (off_i)
        `SOC_BOOT:    boot_q   <= wdata_i;
        `SOC_CLKGATE: gate_q   <= wdata_i[`PERIPH_NUM_SLOTS-2:0];
        `SOC_PADMUX:  padmux_q <= wdata_i;
        default:      ;
      endcase
    end
  end

  // Bit 3 is the SoC slot itself, always on
  assign clk_gate_o  = {1'b1, gate_q};
  assign boot_addr_o = boot_q;
  assign pad_mux_o   = padmux_q;

  //////////////////////////////////////////////////
  // Read mux
  //////////////////////////////////////////////////

  always_comb begin
    rdata_o = '0;
    // Zero outside a read strobe
    if (rd_i) begin
      case (off_i)
        `SOC_BOOT:    rdata_o = boot_q;
        `SOC_CLKGATE: rdata_o = word_t'(clk_gate_o);
        `SOC_PADMUX:  rdata_o = padmux_q;
        default:      rdata_o = '0;
      endcase
    end
  end

endmodule

//--- verilog/periph_gpio.sv
/*
 * GPIO slot with direction, output and interrupt enable registers.
 * Pins pass a two-flop synchroniser; enabled rising edges set sticky
 * STATUS bits, cleared by reading STATUS. gpio_event_o is their OR.
 */
`timescale 1ns/1ps
`include "periph_consts.svh"

module periph_gpio (
  input  logic                 clk_int,
  input  logic                 rst_n_i,
  input  logic                 wr_i,
  input  logic                 rd_i,
  input  periph_pkg::reg_off_t off_i,
  input  periph_pkg::word_t    wdata_i,
  input  logic                 run_en_i,
  input  periph_pkg::word_t    gpio_in_i,
  output periph_pkg::word_t    rdata_o,
  output periph_pkg::word_t    gpio_out_o,
  output periph_pkg::word_t    gpio_dir_o,
  output logic                 gpio_event_o
);
  import periph_pkg::*;

  word_t                           dir_q;
  word_t                           out_q;
  word_t                           inten_q;
  word_t                           status_q;
  word_t [`GPIO_SYNC_STAGES-1:0]   sync_q;
  word_t                           prev_q;
  word_t                           pin_s;
  word_t                           rise;
  logic                            status_rd;

  //////////////////////////////////////////////////
  // Input synchroniser and edge detect
  //////////////////////////////////////////////////

  assign pin_s     = sync_q[`GPIO_SYNC_STAGES-1];
  assign rise      = pin_s & ~prev_q & inten_q;
  assign status_rd = rd_i && (off_i == `GPIO_STATUS);

  always_ff @(posedge clk_int or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync_q   <= '0;
      prev_q   <= '0;
      status_q <= '0;
    end else begin
      sync_q <= {sync_q[`GPIO_SYNC_STAGES-2:0], gpio_in_i};
      prev_q <= pin_s;
      // Edge in the same cycle as the read survives the clear
      if (status_rd) begin
        status_q <= run_en_i ? rise : '0;
      end else if (run_en_i) begin
        status_q <= status_q | rise;
      end
    end
  end

  //////////////////////////////////////////////////
  // Control registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk_int or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dir_q   <= '0;
      out_q   <= '0;
      inten_q <= '0;
    end else if (wr_i) begin
      case (off_i)
        `GPIO_DIR:   dir_q   <= wdata_i;
        `GPIO_OUT:   out_q   <= wdata_i;
        `GPIO_INTEN: inten_q <= wdata_i;
        default:     ;
      endcase
    end
  end

  always_comb begin
    case (off_i)
      `GPIO_DIR:    rdata_o = dir_q;
      `GPIO_IN:     rdata_o = pin_s;
      `GPIO_OUT:    rdata_o = out_q;
      `GPIO_INTEN:  rdata_o = inten_q;
      `GPIO_STATUS: rdata_o = status_q;
      default:      rdata_o = '0;
    endcase
  end

  assign gpio_dir_o   = dir_q;
  assign gpio_out_o   = out_q;
  assign gpio_event_o = |status_q;

endmodule

//--- verilog/periph_timer.sv
/*
 * Single compare timer. CTRL bit 0 runs it, CTRL bits 3..1 pick a
 * prescale of 2**n. COUNT steps once per tick and wraps to zero when
 * it equals CMP, with a one-cycle pulse on cmp_irq_o.
 */
`timescale 1ns/1ps
`include "periph_consts.svh"

module periph_timer (
  input  logic                 clk_int,
  input  logic                 rst_n_i,
  input  logic                 wr_i,
  input  periph_pkg::reg_off_t off_i,
  input  periph_pkg::word_t    wdata_i,
  input  logic                 run_en_i,
  output periph_pkg::word_t    rdata_o,
  output logic                 cmp_irq_o
);
  import periph_pkg::*;

  word_t      count_q;
  word_t      cmp_q;
  logic [3:0] ctrl_q;
  logic [6:0] presc_q;
  logic [6:0] presc_lim;
  logic       tick;
  logic       match;

  //////////////////////////////////////////////////
  // Prescaler
  //////////////////////////////////////////////////

  // Shift by 7 wraps to zero, so the limit becomes 127
  assign presc_lim = (7'd1 << ctrl_q[3:1]) - 7'd1;
  assign tick      = ctrl_q[0] && run_en_i && (presc_q == presc_lim);
  assign match     = tick && (count_q == cmp_q);

  //////////////////////////////////////////////////
  // Counter, registers and pulse
  //////////////////////////////////////////////////

  always_ff @(posedge clk_int or negedge rst_n_i) begin
    if (!rst_n_i) begin
      count_q   <= '0;
      cmp_q     <= '0;
      ctrl_q    <= '0;
      presc_q   <= '0;
      cmp_irq_o <= 1'b0;
    end else begin
      cmp_irq_o <= match;
      // Stopped timer restarts from a fresh prescale period
      if (!ctrl_q[0]) begin
        presc_q <= '0;
      end else if (run_en_i) begin
        presc_q <= tick ? '0 : presc_q + 7'd1;
      end
      if (match) begin
        count_q <= '0;
      end else if (tick) begin
        count_q <= count_q + 1'b1;
      end
      // Bus write wins over the count step
      if (wr_i) begin
        case (off_i)
          `TIM_COUNT: count_q <= wdata_i;
          `TIM_CTRL:  ctrl_q  <= wdata_i[3:0];
          `TIM_CMP:   cmp_q   <= wdata_i;
          default:    ;
        endcase
      end
    end
  end

  always_comb begin
    case (off_i)
      `TIM_COUNT: rdata_o = count_q;
      `TIM_CTRL:  rdata_o = word_t'(ctrl_q);
      `TIM_CMP:   rdata_o = cmp_q;
      default:    rdata_o = '0;
    endcase
  end

  a_pulse: assert property (@(posedge clk_int) disable iff (!rst_n_i)
    cmp_irq_o |=> !cmp_irq_o);

endmodule

//--- verilog/periph_event_unit.sv
/*
 * Event unit. Latches peripheral events into a 32-bit pending word,
 * cleared by writing ones to PENDING, and masks it onto irq_o.
 * Only the GPIO and timer lines have sources in this subsystem.
 */
`timescale 1ns/1ps
`include "periph_consts.svh"

module periph_event_unit (
  input  logic                 clk_int,
  input  logic                 rst_n_i,
  input  logic                 wr_i,
  input  periph_pkg::reg_off_t off_i,
  input  periph_pkg::word_t    wdata_i,
  input  logic                 gpio_event_i,
  input  logic                 timer_irq_i,
  output periph_pkg::word_t    rdata_o,
  output periph_pkg::word_t    irq_o
);
  import periph_pkg::*;

  word_t pending_q;
  word_t mask_q;
  word_t evt_set;
  word_t evt_clr;

  //////////////////////////////////////////////////
  // Event sources
  //////////////////////////////////////////////////

  always_comb begin
    evt_set                 = '0;
    evt_set[`EVT_GPIO_BIT]  = gpio_event_i;
    evt_set[`EVT_TIMER_BIT] = timer_irq_i;
  end

  // Write-one-clear on PENDING
  assign evt_clr = (wr_i && off_i == `EVT_PENDING) ? wdata_i : '0;

  always_ff @(posedge clk_int or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pending_q <= '0;
      mask_q    <= '0;
    end else begin
      // Source high in the clear cycle keeps its bit
      pending_q <= (pending_q & ~evt_clr) | evt_set;
      if (wr_i && off_i == `EVT_MASK) begin
        mask_q <= wdata_i;
      end
    end
  end

  //////////////////////////////////////////////////
  // Read mux and interrupt vector
  //////////////////////////////////////////////////

  always_comb begin
    case (off_i)
      `EVT_MASK:    rdata_o = mask_q;
      `EVT_PENDING: rdata_o = pending_q;
      default:      rdata_o = '0;
    endcase
  end

  assign irq_o = pending_q & mask_q;

endmodule

//--- verilog/periph_sub.sv
/*
 * Top of the APB peripheral subsystem. Connects the decoder to the
 * GPIO, timer, event unit and SoC control slots.
 */
`timescale 1ns/1ps
`include "periph_consts.svh"

module periph_sub (
  input  logic              clk_int,
  input  logic              rst_n_i,
  input  logic              psel_i,
  input  logic              penable_i,
  input  logic              pwrite_i,
  input  periph_pkg::word_t paddr_i,
  input  periph_pkg::word_t pwdata_i,
  output periph_pkg::word_t prdata_o,
  output logic              pready_o,
  output logic              pslverr_o,
  input  periph_pkg::word_t gpio_in_i,
  output periph_pkg::word_t gpio_out_o,
  output periph_pkg::word_t gpio_dir_o,
  output periph_pkg::word_t irq_o,
  output periph_pkg::word_t boot_addr_o,
  output periph_pkg::word_t pad_mux_o
);
  import periph_pkg::*;

  slot_vec_t slot_wr;
  slot_vec_t slot_rd;
  slot_vec_t clk_gate;
  reg_off_t  reg_off;
  word_t     gpio_rdata;
  word_t     timer_rdata;
  word_t     evt_rdata;
  word_t     soc_rdata;
  logic      gpio_event;
  logic      timer_irq;

  //////////////////////////////////////////////////
  // APB decoder
  //////////////////////////////////////////////////

  periph_apb_decode decode0 (
    .clk_int       ( clk_int     ),
    .rst_n_i       ( rst_n_i     ),
    .psel_i        ( psel_i      ),
    .penable_i     ( penable_i   ),
    .pwrite_i      ( pwrite_i    ),
    .paddr_i       ( paddr_i     ),
    .clk_gate_i    ( clk_gate    ),
    .gpio_rdata_i  ( gpio_rdata  ),
    .timer_rdata_i ( timer_rdata ),
    .evt_rdata_i   ( evt_rdata   ),
    .soc_rdata_i   ( soc_rdata   ),
    .slot_wr_o     ( slot_wr     ),
    .slot_rd_o     ( slot_rd     ),
    .reg_off_o     ( reg_off     ),
    .prdata_o      ( prdata_o    ),
    .pready_o      ( pready_o    ),
    .pslverr_o     ( pslverr_o   )
  );

  //////////////////////////////////////////////////
  // Peripheral slots
  //////////////////////////////////////////////////

  periph_gpio gpio0 (
    .clk_int      ( clk_int                       ),
    .rst_n_i      ( rst_n_i                       ),
    .wr_i         ( slot_wr[`PERIPH_SLOT_GPIO]    ),
    .rd_i         ( slot_rd[`PERIPH_SLOT_GPIO]    ),
    .off_i        ( reg_off                       ),
    .wdata_i      ( pwdata_i                      ),
    .run_en_i     ( clk_gate[`CLKGATE_GPIO_BIT]   ),
    .gpio_in_i    ( gpio_in_i                     ),
    .rdata_o      ( gpio_rdata                    ),
    .gpio_out_o   ( gpio_out_o                    ),
    .gpio_dir_o   ( gpio_dir_o                    ),
    .gpio_event_o ( gpio_event                    )
  );

  periph_timer timer0 (
    .clk_int   ( clk_int                        ),
    .rst_n_i   ( rst_n_i                        ),
    .wr_i      ( slot_wr[`PERIPH_SLOT_TIMER]    ),
    .off_i     ( reg_off                        ),
    .wdata_i   ( pwdata_i                       ),
    .run_en_i  ( clk_gate[`CLKGATE_TIMER_BIT]   ),
    .rdata_o   ( timer_rdata                    ),
    .cmp_irq_o ( timer_irq                      )
  );

  periph_event_unit event0 (
    .clk_int      ( clk_int                     ),
    .rst_n_i      ( rst_n_i                     ),
    .wr_i         ( slot_wr[`PERIPH_SLOT_EVENT] ),
    .off_i        ( reg_off                     ),
    .wdata_i      ( pwdata_i                    ),
    .gpio_event_i ( gpio_event                  ),
    .timer_irq_i  ( timer_irq                   ),
    .rdata_o      ( evt_rdata                   ),
    .irq_o        ( irq_o                       )
  );

  periph_soc_ctrl soc0 (
    .clk_int     ( clk_int                   ),
    .rst_n_i     ( rst_n_i                   ),
    .wr_i        ( slot_wr[`PERIPH_SLOT_SOC] ),
    .rd_i        ( slot_rd[`PERIPH_SLOT_SOC] ),
    .off_i       ( reg_off                   ),
    .wdata_i     ( pwdata_i                  ),
    .rdata_o     ( soc_rdata                 ),
    .boot_addr_o ( boot_addr_o               ),
    .clk_gate_o  ( clk_gate                  ),
    .pad_mux_o   ( pad_mux_o                 )
  );

endmodule

//--- sim/periph_sub_tb.sv
/*
 * Testbench of the APB peripheral subsystem. Runs SoC control, decode,
 * GPIO, interrupt and timer tests over APB with random values from a
 * fixed seed, and checks the DUT against a register model kept here.
 */
`timescale 1ns/1ps
`include "periph_consts.svh"

module periph_sub_tb;
  import periph_pkg::*;

  // Sum of the worst-case test lengths plus margin
  localparam int MAX_CYCLES = 4000;

  logic  clk_int;
  logic  rst_n_i;
  logic  psel_i;
  logic  penable_i;
  logic  pwrite_i;
  word_t paddr_i;
  word_t pwdata_i;
  word_t prdata_o;
  logic  pready_o;
  logic  pslverr_o;
  word_t gpio_in_i;
  word_t gpio_out_o;
  word_t gpio_dir_o;
  word_t irq_o;
  word_t boot_addr_o;
  word_t pad_mux_o;

  // Register model
  word_t  m_boot;
  word_t  m_padmux;
  word_t  m_dir;
  word_t  m_out;
  word_t  m_inten;
  word_t  m_mask;
  integer seed;
  int     err_count;
  int     check_count;
  int     cycle_count;

  periph_sub dut0 (
    .clk_int     ( clk_int     ),
    .rst_n_i     ( rst_n_i     ),
    .psel_i      ( psel_i      ),
    .penable_i   ( penable_i   ),
    .pwrite_i    ( pwrite_i    ),
    .paddr_i     ( paddr_i     ),
    .pwdata_i    ( pwdata_i    ),
    .prdata_o    ( prdata_o    ),
    .pready_o    ( pready_o    ),
    .pslverr_o   ( pslverr_o   ),
    .gpio_in_i   ( gpio_in_i   ),
    .gpio_out_o  ( gpio_out_o  ),
    .gpio_dir_o  ( gpio_dir_o  ),
    .irq_o       ( irq_o       ),
    .boot_addr_o ( boot_addr_o ),
    .pad_mux_o   ( pad_mux_o   )
  );

  always #5 clk_int = ~clk_int;

  // Run limit
  always @(posedge clk_int) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: tests did not finish within %0d cycles", MAX_CYCLES);
      $display("Simulation failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  // Slot number in bits 15..12, word offset in bits 11..2
  function automatic word_t reg_addr(input int slot, input reg_off_t off);
    reg_addr = (word_t'(slot) << `PERIPH_SLOT_LSB) | (word_t'(off) << 2);
  endfunction

  task automatic check_value(input string name, input word_t exp, input word_t act);
    check_count++;
    if (exp !== act) begin
      err_count++;
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // Setup cycle, then access cycle; response sampled mid access phase
  task automatic apb_write(input word_t addr, input word_t data, output logic err);
    @(posedge clk_int);
    psel_i    <= 1'b1;
    penable_i <= 1'b0;
    pwrite_i  <= 1'b1;
    paddr_i   <= addr;
    pwdata_i  <= data;
    @(posedge clk_int);
    penable_i <= 1'b1;
    @(negedge clk_int);
    err = pslverr_o;
    check_value("pready_wr", 1, pready_o);
    @(posedge clk_int);
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
    pwrite_i  <= 1'b0;
  endtask

  task automatic apb_read(input word_t addr, output word_t data, output logic err);
    @(posedge clk_int);
    psel_i    <= 1'b1;
    penable_i <= 1'b0;
    pwrite_i  <= 1'b0;
    paddr_i   <= addr;
    @(posedge clk_int);
    penable_i <= 1'b1;
    @(negedge clk_int);
    data = prdata_o;
    err  = pslverr_o;
    check_value("pready_rd", 1, pready_o);
    @(posedge clk_int);
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
  endtask

  // Write expected to be accepted
  task automatic write_reg(input string name, input word_t addr, input word_t data);
    logic err;
    apb_write(addr, data, err);
    check_value({name, "_err"}, 0, err);
  endtask

  task automatic read_check(input string name, input word_t addr, input word_t exp);
    word_t data;
    logic  err;
    apb_read(addr, data, err);
    check_value({name, "_err"}, 0, err);
    check_value(name, exp, data);
  endtask

  // Polls an irq line once per cycle up to a cycle limit
  task automatic wait_irq(input string name, input int line, input int limit);
    int n;
    n = 0;
    while (irq_o[line] !== 1'b1 && n < limit) begin
      @(negedge clk_int);
      n++;
    end
    check_count++;
    if (irq_o[line] !== 1'b1) begin
      err_count++;
      $display("ERROR %s: irq line %0d did not rise within %0d cycles", name, line, limit);
    end
  endtask

  // Timer off for a while, back on, then sample COUNT
  task automatic freeze_round(input int idle, output word_t count);
    logic err;
    write_reg("timer_gate_off", reg_addr(`PERIPH_SLOT_SOC, `SOC_CLKGATE), 32'h5);
    repeat (idle) @(posedge clk_int);
    write_reg("timer_gate_on", reg_addr(`PERIPH_SLOT_SOC, `SOC_CLKGATE), 32'h7);
    apb_read(reg_addr(`PERIPH_SLOT_TIMER, `TIM_COUNT), count, err);
    check_value("timer_count_err", 0, err);
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    word_t rdata;
    word_t val;
    word_t c1;
    word_t c2;
    word_t c3;
    logic  err;
    int    slot;
    int    b;
    int    cmp;
    int    presc;

    seed        = 32'ha85bf14a;
    err_count   = 0;
    check_count = 0;
    cycle_count = 0;
    clk_int     = 1'b0;
    rst_n_i     = 1'b0;
    psel_i      = 1'b0;
    penable_i   = 1'b0;
    pwrite_i    = 1'b0;
    paddr_i     = '0;
    pwdata_i    = '0;
    gpio_in_i   = '0;
    m_dir       = '0;
    m_out       = '0;
    m_mask      = '0;
    repeat (2) @(posedge clk_int);
    rst_n_i <= 1'b1;

    // SoC control reset values and random writes
    read_check("soc_boot_reset", reg_addr(`PERIPH_SLOT_SOC, `SOC_BOOT), `PERIPH_BOOT_RESET);
    read_check("soc_clkgate_reset", reg_addr(`PERIPH_SLOT_SOC, `SOC_CLKGATE), 32'hF);
    @(negedge clk_int);
    check_value("boot_addr_reset", `PERIPH_BOOT_RESET, boot_addr_o);
    check_value("pad_mux_reset", 0, pad_mux_o);
    for (int i = 0; i < 4; i++) begin
      m_boot   = $random(seed);
      m_padmux = $random(seed);
      write_reg("soc_boot_wr", reg_addr(`PERIPH_SLOT_SOC, `SOC_BOOT), m_boot);
      write_reg("soc_padmux_wr", reg_addr(`PERIPH_SLOT_SOC, `SOC_PADMUX), m_padmux);
      read_check("soc_boot", reg_addr(`PERIPH_SLOT_SOC, `SOC_BOOT), m_boot);
      read_check("soc_padmux", reg_addr(`PERIPH_SLOT_SOC, `SOC_PADMUX), m_padmux);
      @(negedge clk_int);
      check_value("boot_addr_port", m_boot, boot_addr_o);
      check_value("pad_mux_port", m_padmux, pad_mux_o);
    end

    // Unmapped slots answer with an error and zero data
    for (int i = 0; i < 4; i++) begin
      slot = 4 + ({$random(seed)} % 12);
      apb_read(reg_addr(slot, reg_off_t'($random(seed))), rdata, err);
      check_value("unmapped_rd_err", 1, err);
      check_value("unmapped_rd_data", 0, rdata);
      apb_write(reg_addr(slot, reg_off_t'($random(seed))), $random(seed), err);
      check_value("unmapped_wr_err", 1, err);
    end

    // Disabled GPIO rejects accesses and keeps OUT
    m_out = $random(seed);
    write_reg("gpio_out_pre", reg_addr(`PERIPH_SLOT_GPIO, `GPIO_OUT), m_out);
    write_reg("gpio_gate_off", reg_addr(`PERIPH_SLOT_SOC, `SOC_CLKGATE), 32'h6);
    read_check("soc_clkgate", reg_addr(`PERIPH_SLOT_SOC, `SOC_CLKGATE), 32'hE);
    apb_write(reg_addr(`PERIPH_SLOT_GPIO, `GPIO_OUT), $random(seed), err);
    check_value("gpio_off_wr_err", 1, err);
    apb_read(reg_addr(`PERIPH_SLOT_GPIO, `GPIO_OUT), rdata, err);
    check_value("gpio_off_rd_err", 1, err);
    check_value("gpio_off_rd_data", 0, rdata);
    @(negedge clk_int);
    check_value("gpio_off_out_port", m_out, gpio_out_o);
    write_reg("gpio_gate_on", reg_addr(`PERIPH_SLOT_SOC, `SOC_CLKGATE), 32'h7);
    read_check("gpio_out_kept", reg_addr(`PERIPH_SLOT_GPIO, `GPIO_OUT), m_out);

    // GPIO direction and output
    for (int i = 0; i < 4; i++) begin
      m_dir = $random(seed);
      m_out = $random(seed);
      write_reg("gpio_dir_wr", reg_addr(`PERIPH_SLOT_GPIO, `GPIO_DIR), m_dir);
      write_reg("gpio_out_wr", reg_addr(`PERIPH_SLOT_GPIO, `GPIO_OUT), m_out);
      read_check("gpio_dir", reg_addr(`PERIPH_SLOT_GPIO, `GPIO_DIR), m_dir);
      read_check("gpio_out", reg_addr(`PERIPH_SLOT_GPIO, `GPIO_OUT), m_out);
      @(negedge clk_int);
      check_value("gpio_dir_port", m_dir, gpio_dir_o);
      check_value("gpio_out_port", m_out, gpio_out_o);
    end

    // Pins through the synchroniser
    for (int i = 0; i < 4; i++) begin
      val = $random(seed);
      @(posedge clk_int);
      gpio_in_i <= val;
      repeat (3) @(posedge clk_int);
      read_check("gpio_in", reg_addr(`PERIPH_SLOT_GPIO, `GPIO_IN), val);
    end

    // GPIO edge interrupt into event line 25
    @(posedge clk_int);
    gpio_in_i <= '0;
    repeat (4) @(posedge clk_int);
    b       = {$random(seed)} % 32;
    m_inten = $random(seed) | (word_t'(1) << b);
    m_mask  = (word_t'(1) << `EVT_GPIO_BIT) | (word_t'(1) << `EVT_TIMER_BIT);
    write_reg("gpio_inten_wr", reg_addr(`PERIPH_SLOT_GPIO, `GPIO_INTEN), m_inten);
    write_reg("evt_mask_wr", reg_addr(`PERIPH_SLOT_EVENT, `EVT_MASK), m_mask);
    read_check("evt_mask", reg_addr(`PERIPH_SLOT_EVENT, `EVT_MASK), m_mask);
    @(posedge clk_int);
    gpio_in_i <= word_t'(1) << b;
    // Two sync stages, status flop, pending flop
    repeat (6) @(posedge clk_int);
    @(negedge clk_int);
    check_value("gpio_irq_set", 1, irq_o[`EVT_GPIO_BIT]);
    read_check("evt_pending", reg_addr(`PERIPH_SLOT_EVENT, `EVT_PENDING),
               word_t'(1) << `EVT_GPIO_BIT);
    read_check("gpio_status", reg_addr(`PERIPH_SLOT_GPIO, `GPIO_STATUS), word_t'(1) << b);
    read_check("gpio_status_clr", reg_addr(`PERIPH_SLOT_GPIO, `GPIO_STATUS), 0);
    write_reg("evt_clr_gpio", reg_addr(`PERIPH_SLOT_EVENT, `EVT_PENDING),
              word_t'(1) << `EVT_GPIO_BIT);
    @(negedge clk_int);
    check_value("gpio_irq_clr", 0, irq_o[`EVT_GPIO_BIT]);

    // Timer compare into event line 28
    cmp   = 1 + ({$random(seed)} % 20);
    presc = {$random(seed)} % 4;
    write_reg("tim_cmp_wr", reg_addr(`PERIPH_SLOT_TIMER, `TIM_CMP), cmp);
    write_reg("tim_run", reg_addr(`PERIPH_SLOT_TIMER, `TIM_CTRL), (presc << 1) | 1);
    wait_irq("timer_first_wrap", `EVT_TIMER_BIT, ((cmp + 1) << presc) + 4);
    // Stop before the clear so no new pulse lands on it
    write_reg("tim_stop", reg_addr(`PERIPH_SLOT_TIMER, `TIM_CTRL), presc << 1);
    write_reg("evt_clr_timer", reg_addr(`PERIPH_SLOT_EVENT, `EVT_PENDING),
              word_t'(1) << `EVT_TIMER_BIT);
    @(negedge clk_int);
    check_value("timer_irq_clr", 0, irq_o[`EVT_TIMER_BIT]);
    read_check("tim_ctrl", reg_addr(`PERIPH_SLOT_TIMER, `TIM_CTRL), presc << 1);
    write_reg("tim_rerun", reg_addr(`PERIPH_SLOT_TIMER, `TIM_CTRL), (presc << 1) | 1);
    wait_irq("timer_next_wrap", `EVT_TIMER_BIT, ((cmp + 1) << presc) + 4);

    // Free-running count, no wrap
    write_reg("tim_halt", reg_addr(`PERIPH_SLOT_TIMER, `TIM_CTRL), 0);
    write_reg("tim_cmp_max", reg_addr(`PERIPH_SLOT_TIMER, `TIM_CMP), 32'hFFFF_FFFF);
    write_reg("tim_count_wr", reg_addr(`PERIPH_SLOT_TIMER, `TIM_COUNT), 0);
    write_reg("tim_run_fast", reg_addr(`PERIPH_SLOT_TIMER, `TIM_CTRL), 1);
    apb_read(reg_addr(`PERIPH_SLOT_TIMER, `TIM_COUNT), c1, err);
    check_value("timer_count_err", 0, err);
    // Same enabled time per round, so equal steps mean a frozen count
    freeze_round(5, c2);
    freeze_round(100, c3);
    check_value("timer_freeze", c2 - c1, c3 - c2);

    $display("Checks: %0d, errors: %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- periph_sub.f
+incdir+verilog
verilog/periph_pkg.sv
verilog/periph_apb_decode.sv
verilog/periph_soc_ctrl.sv
verilog/periph_gpio.sv
verilog/periph_timer.sv
verilog/periph_event_unit.sv
verilog/periph_sub.sv
sim/periph_sub_tb.sv

//--- Bender.yml
package:
  name: periph_sub

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/periph_pkg.sv
      - verilog/periph_apb_decode.sv
      - verilog/periph_soc_ctrl.sv
      - verilog/periph_gpio.sv
      - verilog/periph_timer.sv
      - verilog/periph_event_unit.sv
      - verilog/periph_sub.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - sim/periph_sub_tb.sv
